// File: src/font_pkg.sv
//////////////////////////////////////////////////
// one glyph size for the whole font, 24x24 pixels
// records with codes outside 32..127 are dropped
//////////////////////////////////////////////////
`default_nettype none

package font_pkg;

	// font geometry
	localparam int FIRST_CHAR    = 32;
	localparam int NUM_CHARS     = 96;
	localparam int GLYPH_ROWS    = 24;
	localparam int BYTES_PER_ROW = 3;
	localparam int GLYPH_BYTES   = GLYPH_ROWS * BYTES_PER_ROW;

	// screen cell size in pixels
	localparam int CELL_W = 24;
	localparam int CELL_H = 24;

	// stream markers
	localparam logic [7:0]  HEADER_MARKER = 8'h96;
	localparam logic [31:0] SYNC_WORD     = 32'h55aa0001;

	typedef logic [7:0]  byte_t;
	typedef logic [7:0]  char_code_t;
	typedef logic [6:0]  char_index_t;   // code - FIRST_CHAR
	typedef logic [12:0] glyph_addr_t;
	typedef logic [4:0]  width_t;        // 0..24 pixels

endpackage

`default_nettype wire

// File: src/font_stream_decoder.sv
//////////////////////////////////////////////////
// no back-pressure, one byte per font_valid strobe
// bytes after decode_done are dropped until reset
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module font_stream_decoder (
	input  wire                     clk,
	input  wire                     rst,
	input  font_pkg::byte_t         font_byte,
	input  wire                     font_valid,
	output logic                    glyph_we,
	output font_pkg::glyph_addr_t   glyph_waddr,
	output font_pkg::byte_t         glyph_wdata,
	output logic                    width_we,
	output font_pkg::char_index_t   width_waddr,
	output font_pkg::width_t        width_wdata,
	output logic                    decode_done
);
	import font_pkg::*;

	typedef enum logic [1:0] {
		ST_FILE_HDR,
		ST_SYNC,
		ST_REC_HDR,
		ST_GLYPH
	} state_t;

	state_t      state;
	logic [6:0]  byte_cnt;     // position inside current field
	logic [6:0]  char_cnt;     // valid records written so far
	logic [31:0] sync_sr;
	logic [31:0] sync_next;
	logic        sync_hit;
	logic        byte_ok;
	logic        code_ok;
	char_index_t code_idx;
	width_t      width_q;
	logic        in_range;
	glyph_addr_t glyph_base;

	assign byte_ok   = font_valid && !decode_done;
	assign sync_next = {sync_sr[23:0], font_byte};
	assign sync_hit  = (sync_next == SYNC_WORD);
	assign code_ok   = (font_byte >= FIRST_CHAR) && (font_byte < FIRST_CHAR + NUM_CHARS);
	assign code_idx  = char_index_t'(font_byte - FIRST_CHAR);

	//////////////////////////////////////////////////
	// control
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			state       <= ST_FILE_HDR;
			byte_cnt    <= '0;
			char_cnt    <= '0;
			decode_done <= 1'b0;
			glyph_we    <= 1'b0;
			width_we    <= 1'b0;
		end else begin
			glyph_we <= 1'b0;
			width_we <= 1'b0;
			if (byte_ok) begin
				case (state)
					ST_FILE_HDR: begin
						if (font_byte == HEADER_MARKER)
							state <= ST_SYNC;
					end
					ST_SYNC: begin
						if (sync_hit) begin
							state    <= ST_REC_HDR;
							byte_cnt <= '0;
						end
					end
					ST_REC_HDR: begin
						if (byte_cnt == 7'd1) begin  // code byte
							width_we <= code_ok;
							state    <= ST_GLYPH;
							byte_cnt <= '0;
						end else begin
							byte_cnt <= byte_cnt + 7'd1;
						end
					end
					ST_GLYPH: begin
						glyph_we <= in_range;
						if (byte_cnt == 7'(GLYPH_BYTES - 1)) begin
							state    <= ST_SYNC;
							byte_cnt <= '0;
							if (in_range) begin
								char_cnt <= char_cnt + 7'd1;
								if (char_cnt == 7'(NUM_CHARS - 1))
									decode_done <= 1'b1;
							end
						end else begin
							byte_cnt <= byte_cnt + 7'd1;
						end
					end
					default: state <= ST_FILE_HDR;
				endcase
			end
		end
	end

	//////////////////////////////////////////////////
	// datapath
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (state != ST_SYNC)
			sync_sr <= '0;      // fresh search after every record
		else if (byte_ok)
			sync_sr <= sync_next;

		if (byte_ok && state == ST_REC_HDR) begin
			if (byte_cnt == 7'd0) begin
				width_q <= width_t'(font_byte);
			end else begin
				in_range    <= code_ok;
				glyph_base  <= glyph_addr_t'(code_idx * GLYPH_BYTES);
				width_waddr <= code_idx;
				width_wdata <= width_q;
			end
		end

		if (byte_ok && state == ST_GLYPH) begin
			glyph_waddr <= glyph_base + glyph_addr_t'(byte_cnt);
			glyph_wdata <= font_byte;
		end
	end

endmodule

`default_nettype wire

// File: src/glyph_ram.sv
//////////////////////////////////////////////////
// registered read, one cycle latency, no reset
// read of a word written the same cycle returns old data
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module glyph_ram #(
	parameter int  DEPTH  = 96,
	parameter type word_t = font_pkg::byte_t
) (
	input  wire                     clk,
	input  wire                     we,
	input  wire [$clog2(DEPTH)-1:0] waddr,
	input  word_t                   wdata,
	input  wire [$clog2(DEPTH)-1:0] raddr,
	output word_t                   rdata
);

	word_t mem [DEPTH];

	always_ff @(posedge clk) begin
		if (we)
			mem[waddr] <= wdata;
	end

	always_ff @(posedge clk) begin
		rdata <= mem[raddr];  // read-before-write
	end

endmodule

`default_nettype wire

// File: src/text_layout.sv
//////////////////////////////////////////////////
// fixed three-line screen, all other cells are space
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module text_layout (
	input  wire [4:0]           col,
	input  wire [4:0]           row,
	output font_pkg::char_code_t code
);

	localparam logic [7:0]     SPACE = 8'd32;
	localparam logic [8*7-1:0] TITLE = "FONT:14";   // first char in top byte

	logic in_title;
	logic in_alpha;

	assign in_title = (col >= 5'd2) && (col <= 5'd8);
	assign in_alpha = (col >= 5'd2) && (col <= 5'd27);

	always_comb begin
		code = SPACE;
		case (row)
			5'd1: begin
				if (in_title)
					code = TITLE[(8 - int'(col)) * 8 +: 8];
			end
			5'd2: begin
				if (in_alpha)
					code = 8'("A") + 8'(col) - 8'd2;  // A..Z
			end
			5'd3: begin
				if (in_alpha)
					code = 8'("a") + 8'(col) - 8'd2;  // a..z
			end
			default: code = SPACE;
		endcase
	end

endmodule

`default_nettype wire

// File: src/glyph_renderer.sv
//////////////////////////////////////////////////
// fixed 3-cycle latency, one pixel per cycle max
// cells past column/row 31 render as space
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module glyph_renderer #(
	parameter int X_W = 10,
	parameter int Y_W = 10
) (
	input  wire                     clk,
	input  wire                     rst,
	input  wire [X_W-1:0]           x,
	input  wire [Y_W-1:0]           y,
	input  wire                     pix_valid,
	input  wire                     decode_done,
	output font_pkg::glyph_addr_t   glyph_raddr,
	output font_pkg::char_index_t   width_raddr,
	input  font_pkg::byte_t         glyph_rdata,
	input  font_pkg::width_t        width_rdata,
	output logic                    txt,
	output logic                    txt_valid
);
	import font_pkg::*;

	logic [X_W-1:0] col_full;
	logic [Y_W-1:0] row_full;
	logic [4:0]     col;
	logic [4:0]     row;
	logic [4:0]     px;
	logic [4:0]     py;
	char_code_t     code;
	char_index_t    idx;
	logic [2:0]     bit_pos;

	// stage registers
	logic [2:0] bit_s1, bit_s2;
	logic [4:0] px_s1, px_s2;
	logic       vld_s1, vld_s2;

	//////////////////////////////////////////////////
	// coordinate to cell
	//////////////////////////////////////////////////
	assign col_full = X_W'(x / CELL_W);
	assign row_full = Y_W'(y / CELL_H);
	assign px       = 5'(x % CELL_W);
	assign py       = 5'(y % CELL_H);

	// clip to the layout grid, cell 31 is blank
	assign col = (col_full > 31) ? 5'd31 : 5'(col_full);
	assign row = (row_full > 31) ? 5'd31 : 5'(row_full);

	text_layout u_layout (
		.col  (col),
		.row  (row),
		.code (code)
	);

	assign idx     = char_index_t'(code - FIRST_CHAR);
	assign bit_pos = 3'd7 - px[2:0];   // msb is leftmost

	always_ff @(posedge clk) begin
		// stage 1 addresses
		glyph_raddr <= glyph_addr_t'(idx * GLYPH_BYTES + py * BYTES_PER_ROW + px / 8);
		width_raddr <= idx;
		bit_s1      <= bit_pos;
		px_s1       <= px;
		// stage 2 waits on ram
		bit_s2      <= bit_s1;
		px_s2       <= px_s1;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			vld_s1    <= 1'b0;
			vld_s2    <= 1'b0;
			txt_valid <= 1'b0;
			txt       <= 1'b0;
		end else begin
			vld_s1    <= pix_valid;
			vld_s2    <= vld_s1;
			txt_valid <= vld_s2;
			// stage 3 bit select with width clip
			txt       <= decode_done && (px_s2 < width_rdata) && glyph_rdata[bit_s2];
		end
	end

endmodule

`default_nettype wire

// File: src/font_render.sv
//////////////////////////////////////////////////
// pixels are blank until a full font is decoded
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module font_render #(
	parameter int X_W = 10,
	parameter int Y_W = 10
) (
	input  wire              clk,
	input  wire              rst,
	input  font_pkg::byte_t  font_byte,
	input  wire              font_valid,
	input  wire [X_W-1:0]    x,
	input  wire [Y_W-1:0]    y,
	input  wire              pix_valid,
	output logic             decode_done,
	output logic             txt,
	output logic             txt_valid
);
	import font_pkg::*;

	logic        glyph_we;
	glyph_addr_t glyph_waddr;
	byte_t       glyph_wdata;
	glyph_addr_t glyph_raddr;
	byte_t       glyph_rdata;

	logic        width_we;
	char_index_t width_waddr;
	width_t      width_wdata;
	char_index_t width_raddr;
	width_t      width_rdata;

	font_stream_decoder u_decoder (
		.clk         (clk),
		.rst         (rst),
		.font_byte   (font_byte),
		.font_valid  (font_valid),
		.glyph_we    (glyph_we),
		.glyph_waddr (glyph_waddr),
		.glyph_wdata (glyph_wdata),
		.width_we    (width_we),
		.width_waddr (width_waddr),
		.width_wdata (width_wdata),
		.decode_done (decode_done)
	);

	// glyph bitmaps, 72 bytes per char
	glyph_ram #(.DEPTH(NUM_CHARS * GLYPH_BYTES), .word_t(byte_t)) u_glyph_ram (
		.clk   (clk),
		.we    (glyph_we),
		.waddr (glyph_waddr),
		.wdata (glyph_wdata),
		.raddr (glyph_raddr),
		.rdata (glyph_rdata)
	);

	glyph_ram #(.DEPTH(NUM_CHARS), .word_t(width_t)) u_width_ram (
		.clk   (clk),
		.we    (width_we),
		.waddr (width_waddr),
		.wdata (width_wdata),
		.raddr (width_raddr),
		.rdata (width_rdata)
	);

	glyph_renderer #(.X_W(X_W), .Y_W(Y_W)) u_renderer (
		.clk         (clk),
		.rst         (rst),
		.x           (x),
		.y           (y),
		.pix_valid   (pix_valid),
		.decode_done (decode_done),
		.glyph_raddr (glyph_raddr),
		.width_raddr (width_raddr),
		.glyph_rdata (glyph_rdata),
		.width_rdata (width_rdata),
		.txt         (txt),
		.txt_valid   (txt_valid)
	);

endmodule

`default_nettype wire

// File: dv/font_render_properties.sv
//////////////////////////////////////////////////
// bound into glyph_renderer and font_stream_decoder
// pipe checks only where CHECK_PIPE is set
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module font_render_properties #(
	parameter bit CHECK_PIPE = 1'b1
) (
	input wire clk,
	input wire rst,
	input wire pix_valid,
	input wire txt,
	input wire txt_valid,
	input wire decode_done
);

	int err_cnt = 0;   // failed assertions so far

	// done is sticky until reset
	a_done_sticky: assert property (@(posedge clk) disable iff (rst)
		($past(decode_done) && !$past(rst)) |-> decode_done)
		else begin
			err_cnt++;
			$error("decode_done fell without a reset");
		end

	generate
		if (CHECK_PIPE) begin : g_pipe
			a_latency: assert property (@(posedge clk) disable iff (rst)
				txt_valid == $past(pix_valid, 3))
				else begin
					err_cnt++;
					$error("txt_valid is not pix_valid delayed by 3 cycles");
				end

			a_blank: assert property (@(posedge clk) disable iff (rst)
				!decode_done |-> !txt)
				else begin
					err_cnt++;
					$error("txt high while decode_done is low");
				end
		end
	endgenerate

endmodule

bind glyph_renderer font_render_properties #(.CHECK_PIPE(1'b1)) u_props (
	.clk         (clk),
	.rst         (rst),
	.pix_valid   (pix_valid),
	.txt         (txt),
	.txt_valid   (txt_valid),
	.decode_done (decode_done)
);

bind font_stream_decoder font_render_properties #(.CHECK_PIPE(1'b0)) u_props (
	.clk         (clk),
	.rst         (rst),
	.pix_valid   (1'b0),
	.txt         (1'b0),
	.txt_valid   (1'b0),
	.decode_done (decode_done)
);

`default_nettype wire

// File: dv/font_render_tb.sv
//////////////////////////////////////////////////
// random font, codes 33..127 first, space last
// scan covers cell rows 0..4 and 30 cell columns
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module font_render_tb;
	import font_pkg::*;

	localparam int X_W          = 10;
	localparam int Y_W          = 10;
	localparam int RESET_CYCLES = 10;
	localparam int REC_LEN      = 6 + GLYPH_BYTES;
	localparam int SCAN_W       = 30 * CELL_W;   // past the right edge of the text
	localparam int STREAM_MAX   = 64 + (NUM_CHARS + 8) * (REC_LEN + 4);
	localparam int PIX_MAX      = SCAN_W * 8 * CELL_H + 64;
	localparam int CYCLE_LIMIT  = RESET_CYCLES + STREAM_MAX + PIX_MAX + 1000;

	logic           clk        = 1'b0;
	logic           rst        = 1'b1;
	byte_t          font_byte  = '0;
	logic           font_valid = 1'b0;
	logic [X_W-1:0] x          = '0;
	logic [Y_W-1:0] y          = '0;
	logic           pix_valid  = 1'b0;
	logic           decode_done;
	logic           txt;
	logic           txt_valid;

	integer seed       = 20;
	int     cycle_cnt  = 0;
	logic   model_done = 1'b0;
	byte_t  ref_glyph [NUM_CHARS * GLYPH_BYTES];
	width_t ref_width [NUM_CHARS];
	logic   exp_q [$];
	int     issue_q [$];

	font_render #(.X_W(X_W), .Y_W(Y_W)) dut (
		.clk         (clk),
		.rst         (rst),
		.font_byte   (font_byte),
		.font_valid  (font_valid),
		.x           (x),
		.y           (y),
		.pix_valid   (pix_valid),
		.decode_done (decode_done),
		.txt         (txt),
		.txt_valid   (txt_valid)
	);

	always #20 clk = ~clk;

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_txt(input logic got, input logic exp_bit, input int at_cycle);
		if (got !== exp_bit)
			fail_run($sformatf("Mismatch txt: got 0x%h expected 0x%h at cycle %0d",
				got, exp_bit, at_cycle));
	endtask

	task automatic check_done(input logic got, input logic exp_bit);
		if (got !== exp_bit)
			fail_run($sformatf("Mismatch decode_done: got 0x%h expected 0x%h", got, exp_bit));
	endtask

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////
	function automatic logic expected_txt(input int px_x, input int px_y, input logic done);
		string      title;
		int         col;
		int         row;
		int         px;
		int         py;
		int         idx;
		char_code_t code;
		byte_t      row_byte;
		title = "FONT:14";
		col   = px_x / CELL_W;
		row   = px_y / CELL_H;
		px    = px_x % CELL_W;
		py    = px_y % CELL_H;
		code  = 8'd32;
		if (row == 1 && col >= 2 && col <= 8)
			code = title[col - 2];
		else if (row == 2 && col >= 2 && col <= 27)
			code = 8'(65 + col - 2);
		else if (row == 3 && col >= 2 && col <= 27)
			code = 8'(97 + col - 2);
		idx = int'(code) - FIRST_CHAR;
		if (!done || px >= int'(ref_width[idx]))
			return 1'b0;
		row_byte = ref_glyph[idx * GLYPH_BYTES + py * BYTES_PER_ROW + px / 8];
		return row_byte[7 - px % 8];   // msb is leftmost
	endfunction

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT)
			fail_run("Timeout: the run did not finish within the cycle limit");
	end

	// compare at mid cycle, outputs settled
	always @(negedge clk) begin
		logic exp_bit;
		int   issued;
		if (dut.u_renderer.u_props.err_cnt != 0 || dut.u_decoder.u_props.err_cnt != 0) begin
			fail_run("A bound assertion failed");
		end else if (!rst && txt_valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				fail_run("txt_valid came with no pixel outstanding");
			end else begin
				exp_bit = exp_q.pop_front();
				issued  = issue_q.pop_front();
				if (cycle_cnt != issued + 3)
					fail_run($sformatf("txt_valid came %0d cycles after its strobe",
						cycle_cnt - issued));
				else
					check_txt(txt, exp_bit, cycle_cnt);
			end
		end
	end

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////
	function automatic byte_t rand_byte();
		return byte_t'($random(seed));
	endfunction

	function automatic byte_t garbage_byte();
		byte_t b;
		b = rand_byte();
		if (b == 8'h55 || b == HEADER_MARKER)
			b = b + 8'd1;   // never starts a sync word or ends the header
		return b;
	endfunction

	task automatic send_byte(input byte_t b);
		@(posedge clk);
		#2;
		font_byte  = b;
		font_valid = 1'b1;
	endtask

	task automatic stream_idle();
		@(posedge clk);
		#2;
		font_valid = 1'b0;
	endtask

	task automatic send_garbage(input int n);
		repeat (n) send_byte(garbage_byte());
	endtask

	task automatic send_record(input char_code_t code, input bit store);
		width_t w;
		byte_t  g;
		int     base;
		w    = width_t'(($unsigned($random(seed)) % CELL_W) + 1);
		base = (int'(code) - FIRST_CHAR) * GLYPH_BYTES;
		send_byte(SYNC_WORD[31:24]);
		send_byte(SYNC_WORD[23:16]);
		send_byte(SYNC_WORD[15:8]);
		send_byte(SYNC_WORD[7:0]);
		send_byte(byte_t'(w));
		send_byte(code);
		for (int i = 0; i < GLYPH_BYTES; i++) begin
			g = rand_byte();
			if (store)
				ref_glyph[base + i] = g;
			send_byte(g);
		end
		if (store)
			ref_width[int'(code) - FIRST_CHAR] = w;
	endtask

	task automatic send_pixel(input int px_x, input int px_y);
		@(posedge clk);
		#2;
		x         = X_W'(px_x);
		y         = Y_W'(px_y);
		pix_valid = 1'b1;
		exp_q.push_back(expected_txt(px_x, px_y, model_done));
		issue_q.push_back(cycle_cnt);
	endtask

	task automatic pixel_idle();
		@(posedge clk);
		#2;
		pix_valid = 1'b0;
	endtask

	task automatic scan_rows(input int y_first, input int y_last);
		for (int yy = y_first; yy <= y_last; yy++)
			for (int xx = 0; xx < SCAN_W; xx++)
				send_pixel(xx, yy);
		pixel_idle();
	endtask

	task automatic drain();
		while (exp_q.size() != 0)
			@(posedge clk);
	endtask

	initial begin
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		rst = 1'b0;

		// header, marker, 95 records
		send_garbage(20);
		send_byte(HEADER_MARKER);
		for (int i = 0; i < NUM_CHARS - 1; i++) begin
			if (i % 7 == 3)
				send_garbage(1 + i % 4);
			send_record(char_code_t'(FIRST_CHAR + 1 + i), 1'b1);
		end
		stream_idle();
		check_done(decode_done, 1'b0);

		send_record(8'h10, 1'b0);   // out of range code
		stream_idle();
		check_done(decode_done, 1'b0);

		// pixels before the font is complete
		for (int i = 0; i < 48; i++)
			send_pixel(i * 13, i * 5);
		pixel_idle();
		drain();

		// last record, done one cycle after its final byte
		send_garbage(3);
		send_record(char_code_t'(FIRST_CHAR), 1'b1);
		check_done(decode_done, 1'b0);
		stream_idle();
		check_done(decode_done, 1'b1);
		model_done = 1'b1;

		scan_rows(0, 5 * CELL_H - 1);
		drain();

		// late records must not touch the font
		send_record(8'd65, 1'b0);
		send_record(8'd97, 1'b0);
		send_record(8'd32, 1'b0);
		stream_idle();
		check_done(decode_done, 1'b1);
		scan_rows(CELL_H, 4 * CELL_H - 1);
		drain();

		@(negedge clk);
		if (dut.u_renderer.u_props.err_cnt != 0 || dut.u_decoder.u_props.err_cnt != 0) begin
			fail_run("A bound assertion failed");
		end else begin
			$display("Simulation completed successfully");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: font_render.f
src/font_pkg.sv
src/font_stream_decoder.sv
src/glyph_ram.sv
src/text_layout.sv
src/glyph_renderer.sv
src/font_render.sv
dv/font_render_properties.sv
dv/font_render_tb.sv
